/* verilog/instrFormatPkg.sv */
package instrFormatPkg;

	// ========================================
	// Field widths
	// ========================================

	// Immediate carried by the ALU, load and store format
	localparam int IMM_I_WIDTH = 15;
	// Word displacement carried by the branch format
	localparam int DISP_B_WIDTH = 12;

	// Primary opcode, always in bits 6:0 of the word
	typedef enum logic [6:0] {
		OP_NOP   = 7'h00,
		OP_ADD   = 7'h01,
		OP_ADDI  = 7'h02,
		OP_LDB   = 7'h10,
		OP_LDW   = 7'h11,
		OP_LDT   = 7'h12,
		OP_LDO   = 7'h13,
		OP_STB   = 7'h18,
		OP_STW   = 7'h19,
		OP_STT   = 7'h1A,
		OP_STO   = 7'h1B,
		OP_STI   = 7'h1C,
		OP_STPTR = 7'h1D,
		OP_ASTF  = 7'h1E,
		OP_BCC   = 7'h20,
		OP_BRA   = 7'h21
	} opcode_t;

	typedef logic [4:0] regSpec_t;

	// ========================================
	// Instruction views
	// ========================================

	// Members are listed from the top bit down, so the opcode lands at 6:0
	typedef struct packed {
		logic [24:0] rest;
		opcode_t opcode;
	} anyFmt_t;

	// Register to register ALU form
	typedef struct packed {
		logic [9:0] func;
		regSpec_t rs2;
		regSpec_t rs1;
		regSpec_t rd;
		opcode_t opcode;
	} rFmt_t;

	// For stores the rd slot names the register holding the data
	typedef struct packed {
		logic [IMM_I_WIDTH-1:0] imm;
		regSpec_t rs1;
		regSpec_t rd;
		opcode_t opcode;
	} iFmt_t;

	// The compare and branch form has no destination
	typedef struct packed {
		logic [DISP_B_WIDTH-1:0] disp;
		logic [2:0] cond;
		regSpec_t rs2;
		regSpec_t rs1;
		opcode_t opcode;
	} bFmt_t;

	// One 32-bit word is read through whichever view its opcode calls for
	typedef union packed {
		anyFmt_t any;
		rFmt_t rType;
		iFmt_t iType;
		bFmt_t bType;
	} instruction_t;

endpackage

/* verilog/decodePkg.sv */
package decodePkg;

	// ========================================
	// Decoded bundle widths
	// ========================================

	// Width of immediates and displacements handed to execute
	localparam int DEFAULT_DATA_WIDTH = 64;
	localparam int MEM_SIZE_WIDTH = 2;
	localparam int BR_COND_WIDTH = 3;

	// Memory access size, encoded as log2 of the byte count
	typedef enum logic [MEM_SIZE_WIDTH-1:0] {
		SZ_BYTE  = 2'd0,
		SZ_WYDE  = 2'd1,
		SZ_TETRA = 2'd2,
		SZ_OCTA  = 2'd3
	} memSize_t;

	// Branch conditions follow the cond field of the branch format
	// Unsigned compares sit above the signed ones
	// BC_ALWAYS takes the top code, which no conditional branch uses
	typedef enum logic [BR_COND_WIDTH-1:0] {
		BC_EQ     = 3'd0,
		BC_NE     = 3'd1,
		BC_LT     = 3'd2,
		BC_GE     = 3'd3,
		BC_LTU    = 3'd4,
		BC_GEU    = 3'd5,
		BC_ALWAYS = 3'd7
	} brCond_t;

endpackage

/* verilog/decodeStore.sv */
`timescale 1ns/1ps

module decodeStore
(
	input instrFormatPkg::instruction_t instr,
	output logic isStore,
	output logic isAstf,
	output decodePkg::memSize_t storeSize
);

	import instrFormatPkg::*;
	import decodePkg::*;

	// ========================================
	// Store classification
	// ========================================

	// ASTF computes an address and writes no data, so it stays out of isStore
	always_comb
	begin
		isStore = 1'b0;
		isAstf = 1'b0;
		case (instr.any.opcode)
			OP_STB, OP_STW, OP_STT, OP_STO, OP_STI, OP_STPTR:
				isStore = 1'b1;
			OP_ASTF:
				isAstf = 1'b1;
			default:
				;
		endcase
	end

	// Access size of the store
	// Immediate and pointer stores always move a full octa
	always_comb
	begin
		case (instr.any.opcode)
			OP_STB:
				storeSize = SZ_BYTE;
			OP_STW:
				storeSize = SZ_WYDE;
			OP_STT:
				storeSize = SZ_TETRA;
			OP_STO, OP_STI, OP_STPTR:
				storeSize = SZ_OCTA;
			default:
				storeSize = SZ_BYTE;
		endcase
	end

endmodule

/* verilog/decodeLoad.sv */
`timescale 1ns/1ps

module decodeLoad
(
	input instrFormatPkg::instruction_t instr,
	output logic isLoad,
	output decodePkg::memSize_t loadSize
);

	import instrFormatPkg::*;
	import decodePkg::*;

	// ========================================
	// Load classification
	// ========================================

	// Loads use the same size ladder as stores and climb from byte up to octa
	// Anything that is not a load reports a byte size with isLoad low
	always_comb
	begin
		isLoad = 1'b1;
		case (instr.any.opcode)
			OP_LDB:
				loadSize = SZ_BYTE;
			OP_LDW:
				loadSize = SZ_WYDE;
			OP_LDT:
				loadSize = SZ_TETRA;
			OP_LDO:
				loadSize = SZ_OCTA;
			default:
			begin
				isLoad = 1'b0;
				loadSize = SZ_BYTE;
			end
		endcase
	end

endmodule

/* verilog/decodeBranch.sv */
`timescale 1ns/1ps

module decodeBranch
#(
	parameter int DataWidth = decodePkg::DEFAULT_DATA_WIDTH
)
(
	input instrFormatPkg::instruction_t instr,
	output logic isBranch,
	output decodePkg::brCond_t brCond,
	output logic [DataWidth-1:0] brDisp
);

	import instrFormatPkg::*;
	import decodePkg::*;

	// Displacement counts words, so two zero bits go below it
	logic [DataWidth-1:0] dispExt;

	// ========================================
	// Branch classification
	// ========================================

	// Top bits copy the displacement sign, then the field, then the word shift
	assign dispExt = {{(DataWidth - DISP_B_WIDTH - 2){instr.bType.disp[DISP_B_WIDTH-1]}},
		instr.bType.disp, 2'b00};

	// Conditional branches take their condition from the word itself
	// An unconditional branch ignores the cond field entirely
	always_comb
	begin
		isBranch = 1'b1;
		brCond = brCond_t'(instr.bType.cond);
		brDisp = dispExt;
		case (instr.any.opcode)
			OP_BCC:
				;
			OP_BRA:
				brCond = BC_ALWAYS;
			default:
			begin
				isBranch = 1'b0;
				brCond = BC_EQ;
				brDisp = '0;
			end
		endcase
	end

endmodule

/* verilog/decodeImm.sv */
`timescale 1ns/1ps

module decodeImm
#(
	parameter int DataWidth = decodePkg::DEFAULT_DATA_WIDTH
)
(
	input instrFormatPkg::instruction_t instr,
	output logic hasImm,
	output logic [DataWidth-1:0] immValue
);

	import instrFormatPkg::*;

	// Sign-extended I-format immediate, valid whenever the format applies
	logic [DataWidth-1:0] immExt;

	// ========================================
	// Immediate selection
	// ========================================

	assign immExt = {{(DataWidth - IMM_I_WIDTH){instr.iType.imm[IMM_I_WIDTH-1]}},
		instr.iType.imm};

	// Every format with an immediate today is the I format
	// Loads and stores use it as the address offset, ADDI as the operand
	always_comb
	begin
		case (instr.any.opcode)
			OP_ADDI,
			OP_LDB, OP_LDW, OP_LDT, OP_LDO,
			OP_STB, OP_STW, OP_STT, OP_STO, OP_STI,
			OP_STPTR, OP_ASTF:
				hasImm = 1'b1;
			default:
				hasImm = 1'b0;
		endcase
	end

	// Zero rather than stray field bits when there is no immediate
	always_comb
	begin
		if (hasImm)
			immValue = immExt;
		else
			immValue = '0;
	end

endmodule

/* verilog/instrDecodeStage.sv */
`timescale 1ns/1ps

module instrDecodeStage
#(
	parameter int DataWidth = decodePkg::DEFAULT_DATA_WIDTH
)
(
	input logic clk,
	input logic rstN,
	input instrFormatPkg::instruction_t instr,
	input logic instrValid,
	input logic stall,
	output logic outValid,
	output logic isStore,
	output logic isAstf,
	output logic isLoad,
	output logic isBranch,
	output logic hasImm,
	output logic writesRd,
	output decodePkg::memSize_t memSize,
	output decodePkg::brCond_t brCond,
	output instrFormatPkg::regSpec_t rd,
	output instrFormatPkg::regSpec_t rs1,
	output instrFormatPkg::regSpec_t rs2,
	output logic [DataWidth-1:0] immValue,
	output logic [DataWidth-1:0] brDisp
);

	import instrFormatPkg::*;
	import decodePkg::*;

	// Combinational results of the classifiers, sampled at the stage register
	logic decIsStore;
	logic decIsAstf;
	logic decIsLoad;
	logic decIsBranch;
	logic decHasImm;
	logic decWritesRd;
	memSize_t decStoreSize;
	memSize_t decLoadSize;
	memSize_t decMemSize;
	brCond_t decBrCond;
	regSpec_t decRd;
	regSpec_t decRs1;
	regSpec_t decRs2;
	logic [DataWidth-1:0] decImmValue;
	logic [DataWidth-1:0] decBrDisp;

	// ========================================
	// Classifiers
	// ========================================

	decodeStore uStore (.instr(instr), .isStore(decIsStore), .isAstf(decIsAstf),
		.storeSize(decStoreSize));

	decodeLoad uLoad (.instr(instr), .isLoad(decIsLoad), .loadSize(decLoadSize));

	decodeBranch #(.DataWidth(DataWidth)) uBranch (.instr(instr), .isBranch(decIsBranch),
		.brCond(decBrCond), .brDisp(decBrDisp));

	decodeImm #(.DataWidth(DataWidth)) uImm (.instr(instr), .hasImm(decHasImm),
		.immValue(decImmValue));

	// ========================================
	// Register fields and bundle
	// ========================================

	// Branch words place rs1 and rs2 low and carry no destination
	// I-format words have no rs2 and everything else reads the R view
	always_comb
	begin
		if (decIsBranch)
		begin
			decRd = '0;
			decRs1 = instr.bType.rs1;
			decRs2 = instr.bType.rs2;
		end
		else if (decHasImm)
		begin
			decRd = instr.iType.rd;
			decRs1 = instr.iType.rs1;
			decRs2 = '0;
		end
		else
		begin
			decRd = instr.rType.rd;
			decRs1 = instr.rType.rs1;
			decRs2 = instr.rType.rs2;
		end
	end

	// Register 0 is hardwired, so a write to it is dropped here instead of downstream
	assign decWritesRd = (instr.any.opcode != OP_NOP) && !decIsStore && !decIsAstf &&
		!decIsBranch && (decRd != '0);

	// Size comes from the load side only for loads and from the store side otherwise
	assign decMemSize = decIsLoad ? decLoadSize : decStoreSize;

	// The stage register is held as a whole while the later stages stall
	// Flags are qualified by instrValid so an empty slot never looks like work
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			outValid <= 1'b0;
			isStore <= 1'b0;
			isAstf <= 1'b0;
			isLoad <= 1'b0;
			isBranch <= 1'b0;
			hasImm <= 1'b0;
			writesRd <= 1'b0;
			memSize <= SZ_BYTE;
			brCond <= BC_EQ;
			rd <= '0;
			rs1 <= '0;
			rs2 <= '0;
			immValue <= '0;
			brDisp <= '0;
		end
		else if (!stall)
		begin
			outValid <= instrValid;
			isStore <= instrValid & decIsStore;
			isAstf <= instrValid & decIsAstf;
			isLoad <= instrValid & decIsLoad;
			isBranch <= instrValid & decIsBranch;
			hasImm <= instrValid & decHasImm;
			writesRd <= instrValid & decWritesRd;
			memSize <= decMemSize;
			brCond <= decBrCond;
			rd <= decRd;
			rs1 <= decRs1;
			rs2 <= decRs2;
			immValue <= decImmValue;
			brDisp <= decBrDisp;
		end
	end

endmodule

/* dv/tbInstrDecode.sv */
`timescale 1ns/1ps

module tbInstrDecode;

	import instrFormatPkg::*;
	import decodePkg::*;

	localparam int DataWidth = 64;
	// Edges allowed before a result must show up
	localparam int WaitLimit = 8;

	logic clk;
	logic rstN;
	instruction_t instr;
	logic instrValid;
	logic stall;
	logic outValid;
	logic isStore;
	logic isAstf;
	logic isLoad;
	logic isBranch;
	logic hasImm;
	logic writesRd;
	memSize_t memSize;
	brCond_t brCond;
	regSpec_t rd;
	regSpec_t rs1;
	regSpec_t rs2;
	logic [DataWidth-1:0] immValue;
	logic [DataWidth-1:0] brDisp;

	instrDecodeStage #(.DataWidth(DataWidth)) u_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	// ========================================
	// Reporting and compare tasks
	// ========================================

	task automatic reportMismatch(string msg);
		$display("Error at time %0t: %s", $time, msg);
		$display("Result: FAILED");
		$fatal(1, "Decode mismatch");
	endtask

	task automatic reportTimeout(string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "Decode stage timed out");
	endtask

	task automatic checkBit(string what, logic got, logic exp);
		if (got !== exp)
			reportMismatch($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	task automatic checkSize(string what, memSize_t got, memSize_t exp);
		if (got !== exp)
			reportMismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
	endtask

	task automatic checkCond(string what, brCond_t got, brCond_t exp);
		if (got !== exp)
			reportMismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
	endtask

	task automatic checkReg(string what, regSpec_t got, regSpec_t exp);
		if (got !== exp)
			reportMismatch($sformatf("%s is r%0d, expected r%0d", what, got, exp));
	endtask

	task automatic checkWord(string what, logic [DataWidth-1:0] got,
		logic [DataWidth-1:0] exp);
		if (got !== exp)
			reportMismatch($sformatf("%s is %h, expected %h", what, got, exp));
	endtask

	// ========================================
	// Expected values and driving
	// ========================================

	// Sizes climb from byte through wyde and tetra to octa
	// STI and STPTR always move an octa
	function automatic memSize_t sizeFor(opcode_t op);
		case (op)
			OP_LDB, OP_STB: return SZ_BYTE;
			OP_LDW, OP_STW: return SZ_WYDE;
			OP_LDT, OP_STT: return SZ_TETRA;
			default: return SZ_OCTA;
		endcase
	endfunction

	function automatic logic [DataWidth-1:0] immExpect(logic [IMM_I_WIDTH-1:0] imm);
		logic signed [DataWidth-1:0] wide;
		wide = $signed(imm);
		return wide;
	endfunction

	// Displacement counts words, so the byte offset is four times larger
	function automatic logic [DataWidth-1:0] dispExpect(logic [DISP_B_WIDTH-1:0] disp);
		logic signed [DataWidth-1:0] wide;
		wide = $signed(disp);
		return wide * DataWidth'(4);
	endfunction

	// Returns 1 ns past the edge that brought outValid high
	task automatic waitForOutput();
		int cycles;
		cycles = 0;
		do
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		while (outValid !== 1'b1 && cycles < WaitLimit);
		if (outValid !== 1'b1)
			reportTimeout("Timed out waiting for outValid after presenting an instruction");
		checkBit("result after one edge", cycles == 1, 1'b1);
	endtask

	task automatic idleEdges(int count);
		for (int n = 0; n < count; n++)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic issue(instruction_t word);
		instr = word;
		instrValid = 1'b1;
		waitForOutput();
		instrValid = 1'b0;
	endtask

	// ========================================
	// Directed tests
	// ========================================

	task automatic resetState();
		checkBit("outValid after reset", outValid, 1'b0);
		checkBit("isStore after reset", isStore, 1'b0);
		checkBit("isAstf after reset", isAstf, 1'b0);
		checkBit("isLoad after reset", isLoad, 1'b0);
		checkBit("isBranch after reset", isBranch, 1'b0);
		checkBit("hasImm after reset", hasImm, 1'b0);
		checkBit("writesRd after reset", writesRd, 1'b0);
		checkReg("rd after reset", rd, '0);
		checkWord("immValue after reset", immValue, '0);
	endtask

	task automatic storeDecode();
		opcode_t ops [6];
		instruction_t word;
		ops = '{OP_STB, OP_STW, OP_STT, OP_STO, OP_STI, OP_STPTR};
		foreach (ops[i])
		begin
			word = '0;
			word.iType.opcode = ops[i];
			// A nonzero data register keeps the writesRd check meaningful
			word.iType.rd = regSpec_t'($urandom % 31 + 1);
			word.iType.rs1 = regSpec_t'($urandom);
			word.iType.imm = IMM_I_WIDTH'($urandom);
			issue(word);
			checkBit("isStore on store", isStore, 1'b1);
			checkBit("isLoad on store", isLoad, 1'b0);
			checkBit("hasImm on store", hasImm, 1'b1);
			checkBit("writesRd on store", writesRd, 1'b0);
			checkSize("store size", memSize, sizeFor(ops[i]));
			checkWord("store offset", immValue, immExpect(word.iType.imm));
			checkReg("store base", rs1, word.iType.rs1);
		end
		// The address store form computes an address and is no store
		word.iType.opcode = OP_ASTF;
		word.iType.rd = regSpec_t'($urandom % 31 + 1);
		issue(word);
		checkBit("isAstf on ASTF", isAstf, 1'b1);
		checkBit("isStore on ASTF", isStore, 1'b0);
		checkBit("writesRd on ASTF", writesRd, 1'b0);
	endtask

	task automatic loadAndAluDecode();
		opcode_t ops [4];
		instruction_t word;
		ops = '{OP_LDB, OP_LDW, OP_LDT, OP_LDO};
		foreach (ops[i])
		begin
			word = '0;
			word.iType.opcode = ops[i];
			word.iType.rd = regSpec_t'($urandom % 31 + 1);
			word.iType.rs1 = regSpec_t'($urandom);
			word.iType.imm = IMM_I_WIDTH'($urandom);
			issue(word);
			checkBit("isLoad on load", isLoad, 1'b1);
			checkSize("load size", memSize, sizeFor(ops[i]));
			checkBit("writesRd on load", writesRd, 1'b1);
			checkReg("load destination", rd, word.iType.rd);
		end
		// A load into r0 is not a register write
		word.iType.rd = '0;
		issue(word);
		checkBit("writesRd on load to r0", writesRd, 1'b0);
		word = '0;
		word.rType.opcode = OP_ADD;
		word.rType.rd = regSpec_t'($urandom % 31 + 1);
		word.rType.rs1 = regSpec_t'($urandom);
		word.rType.rs2 = regSpec_t'($urandom);
		issue(word);
		checkBit("hasImm on ADD", hasImm, 1'b0);
		checkReg("ADD rd", rd, word.rType.rd);
		checkReg("ADD rs1", rs1, word.rType.rs1);
		checkReg("ADD rs2", rs2, word.rType.rs2);
	endtask

	task automatic branchDecode();
		instruction_t word;
		for (int k = 0; k < 2; k++)
		begin
			word = '0;
			word.bType.opcode = OP_BCC;
			word.bType.rs1 = regSpec_t'($urandom);
			word.bType.rs2 = regSpec_t'($urandom);
			word.bType.cond = 3'($urandom % 6);
			word.bType.disp = DISP_B_WIDTH'($urandom);
			// First pass branches backward, second forward
			word.bType.disp[DISP_B_WIDTH-1] = (k == 0);
			issue(word);
			checkBit("isBranch on BCC", isBranch, 1'b1);
			checkCond("BCC condition", brCond, brCond_t'(word.bType.cond));
			checkWord("BCC displacement", brDisp, dispExpect(word.bType.disp));
			checkBit("writesRd on BCC", writesRd, 1'b0);
			checkReg("BCC rs2", rs2, word.bType.rs2);
		end
		word.bType.opcode = OP_BRA;
		issue(word);
		checkCond("BRA condition", brCond, BC_ALWAYS);
		checkBit("writesRd on BRA", writesRd, 1'b0);
	endtask

	task automatic stallAndValid();
		instruction_t first;
		instruction_t second;
		first = '0;
		first.iType.opcode = OP_ADDI;
		first.iType.rd = 5'd5;
		first.iType.imm = IMM_I_WIDTH'($urandom);
		second = '0;
		second.iType.opcode = OP_LDO;
		second.iType.rd = 5'd9;
		second.iType.imm = ~first.iType.imm;
		issue(first);
		// Later stages are busy so the waiting load must not enter
		stall = 1'b1;
		instr = second;
		instrValid = 1'b1;
		idleEdges(3);
		checkReg("rd while stalled", rd, first.iType.rd);
		checkBit("isLoad while stalled", isLoad, 1'b0);
		checkWord("immValue while stalled", immValue, immExpect(first.iType.imm));
		stall = 1'b0;
		waitForOutput();
		instrValid = 1'b0;
		checkReg("rd after stall", rd, second.iType.rd);
		checkBit("isLoad after stall", isLoad, 1'b1);
		idleEdges(1);
		checkBit("outValid on empty slot", outValid, 1'b0);
	endtask

	initial
	begin
		void'($urandom(75));
		instr = '0;
		instrValid = 1'b0;
		stall = 1'b0;
		rstN = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		rstN = 1'b1;
		resetState();
		storeDecode();
		loadAndAluDecode();
		branchDecode();
		stallAndValid();
		$display("Result: PASSED");
		$finish;
	end

endmodule

/* filelist.f */
verilog/instrFormatPkg.sv
verilog/decodePkg.sv
verilog/decodeStore.sv
verilog/decodeLoad.sv
verilog/decodeBranch.sv
verilog/decodeImm.sv
verilog/instrDecodeStage.sv
dv/tbInstrDecode.sv

/* run.sh */
#!/bin/sh
# Build the decode stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tbInstrDecode -o simv

output=$(./obj_dir/simv) || true
echo "$output"

if echo "$output" | grep -qx 'Result: PASSED'; then
	exit 0
fi
exit 1
